/* logic/jackal_macros.svh */
`ifndef JACKAL_MACROS_SVH
`define JACKAL_MACROS_SVH

// ============================================================
// Cabinet sizes
// ============================================================
`define NUM_PLAYERS       2
`define ROTARY_W          8                                  // One-hot aim positions
`define ROTARY_HOME       (`ROTARY_W'(1))                    // Position one
`define ROTARY_LAST       (`ROTARY_HOME << (`ROTARY_W - 1))  // Top position
`define ROTARY_DIV_W      23                                 // Normal strobe is 2**23 cycles
`define DIP_BANKS         3

// Loader write stream
`define LOAD_CFG_INDEX    8'd1
`define LOAD_DIP_INDEX    8'd254
`define BOOTLEG_NO_ROTARY 2'd1    // Bootleg board, no rotary hardware

// Host input words
`define PS2_W             11
`define JOY_W             16

// ============================================================
// USB joystick bit positions
// ============================================================
`define JOY_RIGHT         0
`define JOY_LEFT          1
`define JOY_DOWN          2
`define JOY_UP            3
`define JOY_SHOT          4
`define JOY_MISSILE       5
`define JOY_ROT_R         6
`define JOY_ROT_L         7
`define JOY_START         8
`define JOY_COIN          9
`define JOY_PAUSE         10

`endif

/* logic/jackal_pkg.sv */
package jackal_pkg;

	// PS/2 set 2 make codes the decoder knows
	typedef enum logic [7:0] {
		// System keys
		KEY_START1  = 8'h16,  // 1
		KEY_START2  = 8'h1E,  // 2
		KEY_COIN1   = 8'h2E,  // 5
		KEY_COIN2   = 8'h36,  // 6
		KEY_SERVICE = 8'h46,  // 9
		KEY_PAUSE   = 8'h4D,  // P

		// Player 1, arrows and modifiers
		KEY_UP      = 8'h75,
		KEY_DOWN    = 8'h72,
		KEY_LEFT    = 8'h6B,
		KEY_RIGHT   = 8'h74,
		KEY_CTRL    = 8'h14,  // Machine gun
		KEY_ALT     = 8'h11,  // Grenade

		// Player 2, letter block
		KEY_W       = 8'h1D,
		KEY_S       = 8'h1B,
		KEY_A       = 8'h1C,
		KEY_D       = 8'h23,
		KEY_V       = 8'h2A,  // Machine gun
		KEY_B       = 8'h32   // Grenade
	} key_code_e;

	// Step command for the rotary stepper
	typedef enum logic [1:0] {
		ROT_HOLD  = 2'd0,
		ROT_LEFT  = 2'd1,  // Toward the top bit
		ROT_RIGHT = 2'd2   // Toward bit 0
	} rot_dir_e;

endpackage

/* logic/player_ifs.sv */
`timescale 1ns/1ps
`include "jackal_macros.svh"

// ============================================================
// Front end to channel, merged player controls
// ============================================================
interface player_cmd_if;
	logic                  up;
	logic                  down;
	logic                  left;
	logic                  right;
	logic                  shot;
	logic                  missile;
	logic                  start;
	jackal_pkg::rot_dir_e  dir;      // Held rotary lever

	modport driver (
		output up, down, left, right, shot, missile, start, dir
	);

	modport receiver (
		input up, down, left, right, shot, missile, start, dir
	);
endinterface

// ============================================================
// Channel to packer, controls in cabinet order
// ============================================================
interface player_cab_if;
	logic [3:0]           joy;       // Down, up, right, left
	logic [1:0]           buttons;   // Missile, shot
	logic                 start;
	logic [`ROTARY_W-1:0] rotary;    // One-hot aim

	modport source (
		output joy, buttons, start, rotary
	);

	modport sink (
		input joy, buttons, start, rotary
	);
endinterface

/* logic/input_front_end.sv */
`timescale 1ns/1ps
`include "jackal_macros.svh"

module input_front_end #(
	parameter int DIV_W = `ROTARY_DIV_W
) (
	input  logic              CLK_49M,
	input  logic              arst_n,
	input  logic [`PS2_W-1:0] ps2_key,
	input  logic [`JOY_W-1:0] joystick_0,
	input  logic [`JOY_W-1:0] joystick_1,
	input  logic              rotary_fast,   // Halves the strobe period
	player_cmd_if.driver      cmd_p1,
	player_cmd_if.driver      cmd_p2,
	output logic              rotary_tick,
	output logic [1:0]        coin,          // Coin 2, coin 1
	output logic              service,
	output logic              pause_req
);

	// ============================================================
	// Keyboard latches
	// ============================================================
	logic                   ps2_toggle_q;   // Last seen event toggle
	logic                   ps2_event;
	logic                   pressed;
	jackal_pkg::key_code_e  key_code;
	logic [5:0]             kb_p1, kb_p2;   // Joystick bit order
	logic [1:0]             kb_start, kb_coin;
	logic                   kb_service, kb_pause;

	assign ps2_event = ps2_key[10] ^ ps2_toggle_q;
	assign pressed   = ps2_key[9];              // 1 make, 0 break
	assign key_code  = jackal_pkg::key_code_e'(ps2_key[7:0]);

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			ps2_toggle_q <= 1'b0;
			kb_p1        <= '0;
			kb_p2        <= '0;
			kb_start     <= '0;
			kb_coin      <= '0;
			kb_service   <= 1'b0;
			kb_pause     <= 1'b0;
		end else begin
			ps2_toggle_q <= ps2_key[10];
			if (ps2_event) begin
				case (key_code)
					jackal_pkg::KEY_START1:  kb_start[0]          <= pressed;
					jackal_pkg::KEY_START2:  kb_start[1]          <= pressed;
					jackal_pkg::KEY_COIN1:   kb_coin[0]           <= pressed;
					jackal_pkg::KEY_COIN2:   kb_coin[1]           <= pressed;
					jackal_pkg::KEY_SERVICE: kb_service           <= pressed;
					jackal_pkg::KEY_PAUSE:   kb_pause             <= pressed;
					jackal_pkg::KEY_UP:      kb_p1[`JOY_UP]       <= pressed;
					jackal_pkg::KEY_DOWN:    kb_p1[`JOY_DOWN]     <= pressed;
					jackal_pkg::KEY_LEFT:    kb_p1[`JOY_LEFT]     <= pressed;
					jackal_pkg::KEY_RIGHT:   kb_p1[`JOY_RIGHT]    <= pressed;
					jackal_pkg::KEY_CTRL:    kb_p1[`JOY_SHOT]     <= pressed;
					jackal_pkg::KEY_ALT:     kb_p1[`JOY_MISSILE]  <= pressed;
					jackal_pkg::KEY_W:       kb_p2[`JOY_UP]       <= pressed;
					jackal_pkg::KEY_S:       kb_p2[`JOY_DOWN]     <= pressed;
					jackal_pkg::KEY_A:       kb_p2[`JOY_LEFT]     <= pressed;
					jackal_pkg::KEY_D:       kb_p2[`JOY_RIGHT]    <= pressed;
					jackal_pkg::KEY_V:       kb_p2[`JOY_SHOT]     <= pressed;
					jackal_pkg::KEY_B:       kb_p2[`JOY_MISSILE]  <= pressed;
					default: ;                                   // Unknown key, no effect
				endcase
			end
		end
	end

	// Left lever wins over right
	function automatic jackal_pkg::rot_dir_e rot_dir(input logic rot_l, input logic rot_r);
		if (rot_l)
			return jackal_pkg::ROT_LEFT;
		if (rot_r)
			return jackal_pkg::ROT_RIGHT;
		return jackal_pkg::ROT_HOLD;
	endfunction

	// ============================================================
	// Keyboard OR joystick, one register stage
	// ============================================================
	logic [5:0] m_p1, m_p2;
	logic [3:0] sys_q;                      // Pause, service, coin 2, coin 1

	assign m_p1 = kb_p1 | joystick_0[5:0];
	assign m_p2 = kb_p2 | joystick_1[5:0];

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			cmd_p1.up      <= 1'b0;
			cmd_p1.down    <= 1'b0;
			cmd_p1.left    <= 1'b0;
			cmd_p1.right   <= 1'b0;
			cmd_p1.shot    <= 1'b0;
			cmd_p1.missile <= 1'b0;
			cmd_p1.start   <= 1'b0;
			cmd_p1.dir     <= jackal_pkg::ROT_HOLD;
			cmd_p2.up      <= 1'b0;
			cmd_p2.down    <= 1'b0;
			cmd_p2.left    <= 1'b0;
			cmd_p2.right   <= 1'b0;
			cmd_p2.shot    <= 1'b0;
			cmd_p2.missile <= 1'b0;
			cmd_p2.start   <= 1'b0;
			cmd_p2.dir     <= jackal_pkg::ROT_HOLD;
			sys_q          <= '0;
			coin           <= '0;
			service        <= 1'b0;
			pause_req      <= 1'b0;
		end else begin
			cmd_p1.up      <= m_p1[`JOY_UP];
			cmd_p1.down    <= m_p1[`JOY_DOWN];
			cmd_p1.left    <= m_p1[`JOY_LEFT];
			cmd_p1.right   <= m_p1[`JOY_RIGHT];
			cmd_p1.shot    <= m_p1[`JOY_SHOT];
			cmd_p1.missile <= m_p1[`JOY_MISSILE];
			cmd_p1.start   <= kb_start[0] | joystick_0[`JOY_START];
			cmd_p1.dir     <= rot_dir(joystick_0[`JOY_ROT_L], joystick_0[`JOY_ROT_R]);
			cmd_p2.up      <= m_p2[`JOY_UP];
			cmd_p2.down    <= m_p2[`JOY_DOWN];
			cmd_p2.left    <= m_p2[`JOY_LEFT];
			cmd_p2.right   <= m_p2[`JOY_RIGHT];
			cmd_p2.shot    <= m_p2[`JOY_SHOT];
			cmd_p2.missile <= m_p2[`JOY_MISSILE];
			cmd_p2.start   <= kb_start[1] | joystick_1[`JOY_START];
			cmd_p2.dir     <= rot_dir(joystick_1[`JOY_ROT_L], joystick_1[`JOY_ROT_R]);

			// Coin 1 and pause take either stick, coin 2 and service keyboard only
			sys_q[0] <= kb_coin[0] | joystick_0[`JOY_COIN] | joystick_1[`JOY_COIN];
			sys_q[1] <= kb_coin[1];
			sys_q[2] <= kb_service;
			sys_q[3] <= kb_pause | joystick_0[`JOY_PAUSE] | joystick_1[`JOY_PAUSE];

			// Second stage keeps system buttons level with the channel stage
			coin      <= sys_q[1:0];
			service   <= sys_q[2];
			pause_req <= sys_q[3];
		end
	end

	// ============================================================
	// Rotary strobe divider
	// ============================================================
	logic [DIV_W-1:0] div_cnt;

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;   // Free running
	end

	// Fast mode ignores the top bit
	assign rotary_tick = rotary_fast ? (div_cnt[DIV_W-2:0] == '0) : (div_cnt == '0);

endmodule

/* logic/player_channel.sv */
`timescale 1ns/1ps
`include "jackal_macros.svh"

module player_channel (
	input  logic           CLK_49M,
	input  logic           arst_n,
	input  logic           rotary_tick,   // Shared step strobe
	player_cmd_if.receiver cmd,
	player_cab_if.source   cab
);

	// ============================================================
	// One-hot rotary stepper
	// ============================================================
	logic [`ROTARY_W-1:0] rot_pos;
	logic [`ROTARY_W-1:0] rot_next;

	// Next position for the held direction, wrapping at both ends
	always_comb begin
		rot_next = rot_pos;                            // Hold by default
		case (cmd.dir)
			jackal_pkg::ROT_LEFT: begin
				if (rot_pos == `ROTARY_LAST)
					rot_next = `ROTARY_HOME;               // Wrap to bottom
				else
					rot_next = rot_pos << 1;
			end
			jackal_pkg::ROT_RIGHT: begin
				if (rot_pos == `ROTARY_HOME)
					rot_next = `ROTARY_LAST;               // Wrap to top
				else
					rot_next = rot_pos >> 1;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n)
			rot_pos <= `ROTARY_HOME;
		else if (rotary_tick)
			rot_pos <= rot_next;                       // One step per strobe
	end

	assign cab.rotary = rot_pos;

	// ============================================================
	// Controls in cabinet order
	// ============================================================
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			cab.joy     <= '0;
			cab.buttons <= '0;
			cab.start   <= 1'b0;
		end else begin
			cab.joy     <= {cmd.down, cmd.up, cmd.right, cmd.left};
			cab.buttons <= {cmd.missile, cmd.shot};
			cab.start   <= cmd.start;
		end
	end

endmodule

/* logic/cabinet_port_packer.sv */
`timescale 1ns/1ps
`include "jackal_macros.svh"

module cabinet_port_packer (
	input  logic                 CLK_49M,
	input  logic                 arst_n,
	player_cab_if.sink           cab_p1,
	player_cab_if.sink           cab_p2,
	input  logic [1:0]           coin,          // Coin 2, coin 1
	input  logic                 service,
	input  logic                 pause_in,
	input  logic                 ioctl_wr,
	input  logic [7:0]           ioctl_index,
	input  logic [24:0]          ioctl_addr,
	input  logic [7:0]           ioctl_dout,
	output logic [3:0]           p1_joystick,   // Active low from here on
	output logic [3:0]           p2_joystick,
	output logic [1:0]           p1_buttons,
	output logic [1:0]           p2_buttons,
	output logic [`ROTARY_W-1:0] p1_rotary,
	output logic [`ROTARY_W-1:0] p2_rotary,
	output logic [1:0]           btn_start,
	output logic [1:0]           coins,
	output logic                 btn_service,
	output logic [23:0]          dipsw,
	output logic [1:0]           is_bootleg,
	output logic                 pause_req      // Active high
);

	localparam int BANK_W = $clog2(`DIP_BANKS);

	// ============================================================
	// Loader capture
	// ============================================================
	logic [7:0] dip_q [`DIP_BANKS];   // Active low, as in the MRA
	logic [1:0] boot_q;
	logic       dip_wr, cfg_wr;
	logic       no_rotary;

	assign dip_wr    = ioctl_wr && (ioctl_index == `LOAD_DIP_INDEX) && (ioctl_addr < `DIP_BANKS);
	assign cfg_wr    = ioctl_wr && (ioctl_index == `LOAD_CFG_INDEX) && (ioctl_addr == '0);
	assign no_rotary = (boot_q == `BOOTLEG_NO_ROTARY);

	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `DIP_BANKS; i++)
				dip_q[i] <= '0;
			boot_q <= '0;
		end else begin
			if (dip_wr)
				dip_q[ioctl_addr[BANK_W-1:0]] <= ioctl_dout;
			if (cfg_wr)
				boot_q <= ioctl_dout[1:0];               // Board variant code
		end
	end

	// ============================================================
	// Active-low output registers
	// ============================================================
	always_ff @(posedge CLK_49M or negedge arst_n) begin
		if (!arst_n) begin
			p1_joystick <= '1;
			p2_joystick <= '1;
			p1_buttons  <= '1;
			p2_buttons  <= '1;
			p1_rotary   <= ~`ROTARY_HOME;               // Home position, inverted
			p2_rotary   <= ~`ROTARY_HOME;
			btn_start   <= '1;
			coins       <= '1;
			btn_service <= 1'b1;
			dipsw       <= '1;
			is_bootleg  <= '0;
			pause_req   <= 1'b0;
		end else begin
			p1_joystick <= ~cab_p1.joy;
			p2_joystick <= ~cab_p2.joy;
			p1_buttons  <= ~cab_p1.buttons;
			p2_buttons  <= ~cab_p2.buttons;
			btn_start   <= ~{cab_p2.start, cab_p1.start};
			coins       <= ~coin;
			btn_service <= ~service;
			pause_req   <= pause_in;

			// Bootleg boards have no rotary encoders, report no input
			p1_rotary <= no_rotary ? {`ROTARY_W{1'b1}} : ~cab_p1.rotary;
			p2_rotary <= no_rotary ? {`ROTARY_W{1'b1}} : ~cab_p2.rotary;

			dipsw      <= ~{dip_q[2], dip_q[1], dip_q[0]};   // Bank 2 on top
			is_bootleg <= boot_q;
		end
	end

endmodule

/* logic/jackal_inputs.sv */
`timescale 1ns/1ps
`include "jackal_macros.svh"

module jackal_inputs #(
	parameter int ROTARY_DIV_W = `ROTARY_DIV_W
) (
	input  logic                 CLK_49M,
	input  logic                 arst_n,
	input  logic [`PS2_W-1:0]    ps2_key,
	input  logic [`JOY_W-1:0]    joystick_0,
	input  logic [`JOY_W-1:0]    joystick_1,
	input  logic                 rotary_fast,
	input  logic                 ioctl_wr,
	input  logic [7:0]           ioctl_index,
	input  logic [24:0]          ioctl_addr,
	input  logic [7:0]           ioctl_dout,
	output logic [3:0]           p1_joystick,
	output logic [3:0]           p2_joystick,
	output logic [1:0]           p1_buttons,
	output logic [1:0]           p2_buttons,
	output logic [`ROTARY_W-1:0] p1_rotary,
	output logic [`ROTARY_W-1:0] p2_rotary,
	output logic [1:0]           btn_start,
	output logic [1:0]           coins,
	output logic                 btn_service,
	output logic [23:0]          dipsw,
	output logic [1:0]           is_bootleg,
	output logic                 pause_req
);

	player_cmd_if cmd_bus [`NUM_PLAYERS] ();
	player_cab_if cab_bus [`NUM_PLAYERS] ();

	logic       rotary_tick;
	logic [1:0] coin;
	logic       service;
	logic       pause_sys;

	// ============================================================
	// Front end, channels, packer
	// ============================================================
	input_front_end #(
		.DIV_W (ROTARY_DIV_W)
	) front_end_inst (
		.CLK_49M     (CLK_49M),
		.arst_n      (arst_n),
		.ps2_key     (ps2_key),
		.joystick_0  (joystick_0),
		.joystick_1  (joystick_1),
		.rotary_fast (rotary_fast),
		.cmd_p1      (cmd_bus[0]),
		.cmd_p2      (cmd_bus[1]),
		.rotary_tick (rotary_tick),
		.coin        (coin),
		.service     (service),
		.pause_req   (pause_sys)
	);

	for (genvar i = 0; i < `NUM_PLAYERS; i++) begin : chan
		player_channel player_channel_inst (
			.CLK_49M     (CLK_49M),
			.arst_n      (arst_n),
			.rotary_tick (rotary_tick),   // Both players step together
			.cmd         (cmd_bus[i]),
			.cab         (cab_bus[i])
		);
	end

	cabinet_port_packer packer_inst (
		.CLK_49M     (CLK_49M),
		.arst_n      (arst_n),
		.cab_p1      (cab_bus[0]),
		.cab_p2      (cab_bus[1]),
		.coin        (coin),
		.service     (service),
		.pause_in    (pause_sys),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.p1_joystick (p1_joystick),
		.p2_joystick (p2_joystick),
		.p1_buttons  (p1_buttons),
		.p2_buttons  (p2_buttons),
		.p1_rotary   (p1_rotary),
		.p2_rotary   (p2_rotary),
		.btn_start   (btn_start),
		.coins       (coins),
		.btn_service (btn_service),
		.dipsw       (dipsw),
		.is_bootleg  (is_bootleg),
		.pause_req   (pause_req)
	);

endmodule

/* tests/tb_jackal_inputs.sv */
`timescale 1ns/1ps
`include "jackal_macros.svh"

module tb_jackal_inputs;

	// ============================================================
	// DUT ports
	// ============================================================
	logic                  CLK_49M;
	logic                  arst_n;
	logic [`PS2_W-1:0]     ps2_key;
	logic [`JOY_W-1:0]     joystick_0;
	logic [`JOY_W-1:0]     joystick_1;
	logic                  rotary_fast;
	logic                  ioctl_wr;
	logic [7:0]            ioctl_index;
	logic [24:0]           ioctl_addr;
	logic [7:0]            ioctl_dout;
	logic [3:0]            p1_joystick, p2_joystick;
	logic [1:0]            p1_buttons, p2_buttons;
	logic [`ROTARY_W-1:0]  p1_rotary, p2_rotary;
	logic [1:0]            btn_start;
	logic [1:0]            coins;
	logic                  btn_service;
	logic [23:0]           dipsw;
	logic [1:0]            is_bootleg;
	logic                  pause_req;

	jackal_inputs #(
		.ROTARY_DIV_W (6)                  // Strobe every 64 cycles or 32 in fast mode
	) jackal_inputs_inst (.*);

	// Expected cabinet ports as the DUT drives them
	typedef struct packed {
		logic [3:0]  p1_joy;
		logic [3:0]  p2_joy;
		logic [1:0]  p1_btn;
		logic [1:0]  p2_btn;
		logic [7:0]  p1_rot;
		logic [7:0]  p2_rot;
		logic [1:0]  start;
		logic [1:0]  coins;
		logic        service;
		logic [23:0] dipsw;
		logic [1:0]  bootleg;
		logic        pause;
	} ports_t;

	// PS/2 set 2 make codes in keyboard model slot order
	localparam logic [7:0] KEY_CODES [18] = '{
		8'h16, 8'h1E, 8'h2E, 8'h36, 8'h46, 8'h4D,   // Start 1/2, coin 1/2, service, pause
		8'h75, 8'h72, 8'h6B, 8'h74, 8'h14, 8'h11,   // P1 up, down, left, right, ctrl, alt
		8'h1D, 8'h1B, 8'h1C, 8'h23, 8'h2A, 8'h32    // P2 W, S, A, D, V, B
	};
	localparam logic [7:0] KEY_UNKNOWN = 8'h5A;     // Enter key is not decoded

	// ============================================================
	// Model state and bookkeeping
	// ============================================================
	logic [17:0] kb_model;                 // Latched keys by slot
	logic [15:0] joy0_model, joy1_model;
	logic [23:0] dip_model;                // Raw loader bytes with bank 2 on top
	logic [1:0]  boot_model;
	logic [7:0]  pos1_model, pos2_model;   // One-hot aim positions
	logic [31:0] rng;
	ports_t      exp_ports;
	int          cycle;
	int          check_req;
	int          check_ack;
	int          mismatches;
	int          step_errors;
	int          timeouts;

	initial begin
		CLK_49M = 1'b0;
		forever #20 CLK_49M = ~CLK_49M;    // 40 ns period
	end

	always @(posedge CLK_49M) cycle = cycle + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_random(output logic [15:0] r);
		rng = lcg_next(rng);
		r   = rng[31:16];                  // Upper half of the state
	endtask

	// One aim step that wraps at both ends
	function automatic logic [7:0] rot_step(input logic [7:0] pos, input logic left);
		if (left)
			return (pos == 8'h80) ? 8'h01 : (pos << 1);
		return (pos == 8'h01) ? 8'h80 : (pos >> 1);
	endfunction

	// ============================================================
	// Reference model
	// ============================================================
	function automatic ports_t expected_ports(
		input logic [17:0] kb,
		input logic [15:0] j0,
		input logic [15:0] j1,
		input logic [23:0] dip,
		input logic [1:0]  boot,
		input logic [7:0]  pos1,
		input logic [7:0]  pos2
	);
		ports_t     e;
		logic [5:0] m1;
		logic [5:0] m2;
		// Merged as missile, shot, right, left, down, up
		m1 = kb[11:6] | {j0[`JOY_MISSILE], j0[`JOY_SHOT], j0[`JOY_RIGHT],
			j0[`JOY_LEFT], j0[`JOY_DOWN], j0[`JOY_UP]};
		m2 = kb[17:12] | {j1[`JOY_MISSILE], j1[`JOY_SHOT], j1[`JOY_RIGHT],
			j1[`JOY_LEFT], j1[`JOY_DOWN], j1[`JOY_UP]};
		e.p1_joy  = ~{m1[1], m1[0], m1[3], m1[2]};        // Down, up, right, left
		e.p2_joy  = ~{m2[1], m2[0], m2[3], m2[2]};
		e.p1_btn  = ~m1[5:4];
		e.p2_btn  = ~m2[5:4];
		e.start   = ~{kb[1] | j1[`JOY_START], kb[0] | j0[`JOY_START]};
		e.coins   = ~{kb[3], kb[2] | j0[`JOY_COIN] | j1[`JOY_COIN]};   // Coin 2 keyboard only
		e.service = ~kb[4];
		e.pause   = kb[5] | j0[`JOY_PAUSE] | j1[`JOY_PAUSE];
		e.dipsw   = ~dip;
		e.bootleg = boot;
		e.p1_rot  = (boot == `BOOTLEG_NO_ROTARY) ? 8'hFF : ~pos1;   // No encoders on bootleg
		e.p2_rot  = (boot == `BOOTLEG_NO_ROTARY) ? 8'hFF : ~pos2;
		return e;
	endfunction

	// ============================================================
	// Comparator
	// ============================================================
	task automatic compare_field(input string name, input logic [23:0] got,
		input logic [23:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatches++;
		end
	endtask

	// Compares on the falling edge when a check is requested
	always @(negedge CLK_49M) begin
		if (check_ack != check_req) begin
			exp_ports = expected_ports(kb_model, joy0_model, joy1_model, dip_model,
				boot_model, pos1_model, pos2_model);
			compare_field("p1_joystick", 24'(p1_joystick), 24'(exp_ports.p1_joy));
			compare_field("p2_joystick", 24'(p2_joystick), 24'(exp_ports.p2_joy));
			compare_field("p1_buttons", 24'(p1_buttons), 24'(exp_ports.p1_btn));
			compare_field("p2_buttons", 24'(p2_buttons), 24'(exp_ports.p2_btn));
			compare_field("p1_rotary", 24'(p1_rotary), 24'(exp_ports.p1_rot));
			compare_field("p2_rotary", 24'(p2_rotary), 24'(exp_ports.p2_rot));
			compare_field("btn_start", 24'(btn_start), 24'(exp_ports.start));
			compare_field("coins", 24'(coins), 24'(exp_ports.coins));
			compare_field("btn_service", 24'(btn_service), 24'(exp_ports.service));
			compare_field("dipsw", dipsw, exp_ports.dipsw);
			compare_field("is_bootleg", 24'(is_bootleg), 24'(exp_ports.bootleg));
			compare_field("pause_req", 24'(pause_req), 24'(exp_ports.pause));
			check_ack = check_req;
		end
	end

	// ============================================================
	// Stimulus helpers
	// ============================================================
	task automatic settle_and_check();
		int guard;
		repeat (6) @(posedge CLK_49M);     // Longest path is 4 cycles
		check_req++;
		guard = 0;
		while (check_ack != check_req && guard < 4) begin
			@(posedge CLK_49M);
			guard++;
		end
		if (check_ack != check_req) begin
			$display("Timeout: the comparator did not answer a check request");
			timeouts++;
		end
	endtask

	task automatic key_event(input logic [7:0] code, input logic down);
		int k;
		@(posedge CLK_49M);
		ps2_key <= {~ps2_key[10], down, 1'b0, code};   // Toggle marks the event
		for (k = 0; k < 18; k++)
			if (KEY_CODES[k] == code)
				kb_model[k] = down;
		settle_and_check();
	endtask

	task automatic set_joysticks(input logic [15:0] j0, input logic [15:0] j1);
		@(posedge CLK_49M);
		joystick_0 <= j0;
		joystick_1 <= j1;
		joy0_model = j0;
		joy1_model = j1;
	endtask

	task automatic loader_write(input logic wr, input logic [7:0] index,
		input logic [24:0] addr, input logic [7:0] data);
		@(posedge CLK_49M);
		ioctl_wr    <= wr;
		ioctl_index <= index;
		ioctl_addr  <= addr;
		ioctl_dout  <= data;
		@(posedge CLK_49M);
		ioctl_wr <= 1'b0;
		// Only strobed writes to the known slots land
		if (wr && index == `LOAD_DIP_INDEX && int'(addr) < `DIP_BANKS)
			dip_model[8*int'(addr) +: 8] = data;
		if (wr && index == `LOAD_CFG_INDEX && addr == '0)
			boot_model = data[1:0];
		settle_and_check();
	endtask

	// Hold opposite levers on the two sticks and follow the aim steps
	task automatic rotary_run(input logic fast, input logic left, input int steps);
		logic [7:0] want1;
		logic [7:0] want2;
		int         last;
		int         guard;
		int         period;
		int         n;
		period = fast ? 32 : 64;
		last   = -1;
		@(posedge CLK_49M);
		rotary_fast <= fast;
		set_joysticks(left ? 16'h0080 : 16'h0040, left ? 16'h0040 : 16'h0080);
		for (n = 0; n < steps; n++) begin
			guard = 0;
			@(negedge CLK_49M);
			while (p1_rotary === ~pos1_model && guard < 200) begin
				@(negedge CLK_49M);
				guard++;
			end
			if (p1_rotary === ~pos1_model) begin
				$display("Timeout: the rotary port did not step while a lever was held");
				timeouts++;
				set_joysticks(16'h0000, 16'h0000);
				return;
			end
			want1 = rot_step(pos1_model, left);
			want2 = rot_step(pos2_model, !left);
			if (p1_rotary !== ~want1 || p2_rotary !== ~want2) begin
				$display("MISMATCH at %0t: rotary ports %h %h expected %h %h",
					$time, p1_rotary, p2_rotary, ~want1, ~want2);
				step_errors++;
			end
			if (last >= 0 && cycle - last != period) begin
				$display("MISMATCH at %0t: rotary step gap got %0d expected %0d",
					$time, cycle - last, period);
				step_errors++;
			end
			last       = cycle;
			pos1_model = want1;
			pos2_model = want2;
		end
		set_joysticks(16'h0000, 16'h0000);   // Released long before the next strobe
		settle_and_check();
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin : stimulus
		logic [15:0] r;
		logic [15:0] j0;
		logic [15:0] j1;
		int          k;
		int          n;
		int          slot;
		arst_n      <= 1'b0;
		ps2_key     <= '0;
		joystick_0  <= '0;
		joystick_1  <= '0;
		rotary_fast <= 1'b0;
		ioctl_wr    <= 1'b0;
		ioctl_index <= '0;
		ioctl_addr  <= '0;
		ioctl_dout  <= '0;
		kb_model    = '0;
		joy0_model  = '0;
		joy1_model  = '0;
		dip_model   = '0;
		boot_model  = '0;
		pos1_model  = 8'h01;                 // Home
		pos2_model  = 8'h01;
		rng         = 32'd87;
		repeat (8) @(posedge CLK_49M);
		arst_n <= 1'b1;
		settle_and_check();                  // Idle outputs after reset

		// Every decoded key pressed and then released
		for (k = 0; k < 18; k++)
			key_event(KEY_CODES[k], 1'b1);
		for (k = 0; k < 18; k++)
			key_event(KEY_CODES[k], 1'b0);
		for (n = 0; n < 40; n++) begin
			next_random(r);
			slot = int'(r[15:8]) % 19;
			if (slot == 18)
				key_event(KEY_UNKNOWN, r[0]);
			else
				key_event(KEY_CODES[slot], r[0]);
		end
		key_event(KEY_UNKNOWN, 1'b1);
		key_event(KEY_UNKNOWN, 1'b0);
		for (k = 0; k < 18; k++)
			key_event(KEY_CODES[k], 1'b0);  // Keyboard idle

		// Random stick words with the levers off
		for (n = 0; n < 40; n++) begin
			if (n == 24) begin
				key_event(KEY_CODES[10], 1'b1);   // Ctrl
				key_event(KEY_CODES[12], 1'b1);   // W
				key_event(KEY_CODES[3], 1'b1);    // Coin 2
				key_event(KEY_CODES[4], 1'b1);    // Service
				key_event(KEY_CODES[1], 1'b1);    // Start 2
			end
			next_random(r);
			j0 = r & 16'hFF3F;
			next_random(r);
			j1 = r & 16'hFF3F;
			set_joysticks(j0, j1);
			settle_and_check();
		end
		for (k = 0; k < 18; k++)
			key_event(KEY_CODES[k], 1'b0);
		set_joysticks(16'h0000, 16'h0000);

		// Aim stepping through both wraps
		rotary_run(1'b0, 1'b1, 4);
		rotary_run(1'b0, 1'b0, 6);
		rotary_run(1'b1, 1'b1, 4);
		rotary_run(1'b1, 1'b0, 4);

		// Random bytes into each DIP bank in turn and then writes that must not land
		for (n = 0; n < 10; n++) begin
			next_random(r);
			slot = n % `DIP_BANKS;
			loader_write(1'b1, `LOAD_DIP_INDEX, 25'(slot), r[7:0]);
		end
		loader_write(1'b1, `LOAD_DIP_INDEX, 25'd3, 8'hA5);      // Past the last bank
		loader_write(1'b1, `LOAD_DIP_INDEX, 25'h100, 8'h5A);
		loader_write(1'b1, 8'd253, 25'd0, 8'h3C);                // Other index
		loader_write(1'b1, `LOAD_CFG_INDEX, 25'd1, 8'h01);       // Wrong config byte
		loader_write(1'b0, `LOAD_DIP_INDEX, 25'd0, 8'hFF);       // No strobe
		loader_write(1'b0, `LOAD_CFG_INDEX, 25'd0, 8'h01);
		next_random(r);
		loader_write(1'b1, `LOAD_CFG_INDEX, 25'd0, {r[7:2], 2'b01});   // Bootleg board

		$display("Done: %0d mismatches, %0d rotary errors, %0d timeouts",
			mismatches, step_errors, timeouts);
		if (mismatches == 0 && step_errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

/* list.f */
+incdir+logic
logic/jackal_pkg.sv
logic/player_ifs.sv
logic/input_front_end.sv
logic/player_channel.sv
logic/cabinet_port_packer.sv
logic/jackal_inputs.sv
tests/tb_jackal_inputs.sv

/* run.sh */
#!/usr/bin/env bash
# Build the Verilator model of the testbench and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_jackal_inputs \
	-f list.f \
	-o tb_jackal_inputs

sim_out=$(./obj_dir/tb_jackal_inputs)
echo "$sim_out"

if echo "$sim_out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
